// File: tb.f
design/const_line_pkg.sv
design/const_isa_pkg.sv
design/const_slot_extract.sv
design/fp_widen_s2d.sv
design/decode_const.sv
design/decode_const_stage.sv
tb/decode_const_chk.sv
tb/decode_const_tb.sv

// File: Makefile
# Verilator simulation of the constant decode stage

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module decode_const_tb \
		-Mdir obj_dir -o decode_const_tb
	./obj_dir/decode_const_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: tb/decode_const_tb.sv
// ========================================
// Random testbench for the decode stage
// Expected results come from a model of the decode rules
// ========================================

module decode_const_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import const_line_pkg::*;
	import const_isa_pkg::*;

	// One expected output beat
	typedef struct packed {
		imm_t a;
		imm_t b;
		imm_t c;
		logic ha;
		logic hb;
		logic hc;
	} result_t;

	localparam int alu_tests = 40;
	localparam int fp_tests  = 24;
	localparam int br_tests  = 24;
	localparam int mem_tests = 30;
	localparam int mix_tests = 40;
	// Reset, every test, up to two idle cycles per mixed test, and some slack
	localparam int test_cycles = 16 + alu_tests + fp_tests + br_tests + mem_tests
		+ 3 * mix_tests + 12;

	logic   clk;
	logic   arst_n;
	logic   in_valid;
	instr_t ins;
	line_t  line;
	logic   out_valid;
	imm_t   imm_a;
	imm_t   imm_b;
	imm_t   imm_c;
	logic   has_imm_a;
	logic   has_imm_b;
	logic   has_imm_c;

	integer  seed = 43724;
	result_t exp_q [$];
	string   name_q [$];

	decode_const_stage decode_const_stage_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.ins       (ins),
		.line      (line),
		.out_valid (out_valid),
		.imm_a     (imm_a),
		.imm_b     (imm_b),
		.imm_c     (imm_c),
		.has_imm_a (has_imm_a),
		.has_imm_b (has_imm_b),
		.has_imm_c (has_imm_c)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================
	// Reference model
	// ========================================

	// Slots past the end of the line read as zero
	function automatic logic [31:0] slot_word(line_t l, int idx);
		if (idx >= slot_count)
			return 32'd0;
		return l[idx*slot_bits +: slot_bits];
	endfunction

	function automatic imm_t line_const(line_t l, logic [5:0] field);
		int          s;
		logic [31:0] lo;
		s  = int'(field[3:0]);
		lo = slot_word(l, s);
		case (field[5:4])
			2'd0:    return {{56{lo[7]}}, lo[7:0]};
			2'd1:    return {{48{lo[15]}}, lo[15:0]};
			2'd2:    return {{32{lo[31]}}, lo};
			default: return {slot_word(l, s + 1), lo};
		endcase
	endfunction

	function automatic imm_t widen_ref(logic [31:0] f);
		if (f[30:23] == 8'h00)
			return {f[31], 63'd0};
		if (f[30:23] == 8'hff)
			return {f[31], 11'h7ff, f[22:0], 29'd0};
		return {f[31], 11'(f[30:23]) - 11'd127 + 11'd1023, f[22:0], 29'd0};
	endfunction

	// Picks the FP view of an operand when its size code is 32 bits
	function automatic imm_t fp_const(line_t l, logic [5:0] field);
		if (field[5:4] == 2'd2)
			return widen_ref(slot_word(l, int'(field[3:0])));
		return line_const(l, field);
	endfunction

	function automatic result_t ref_decode(instr_t i, line_t l);
		result_t  r;
		imm_t     ca;
		imm_t     cb;
		logic [6:0] op;
		r  = '0;
		ca = line_const(l, i[28:23]);
		cb = line_const(l, i[22:17]);
		op = i[6:0];
		if (op inside {op_add, op_sub, op_and, op_or, op_xor, op_shl})
		begin
			r.a = ca;
			r.b = cb;
			r.c = line_const(l, i[16:11]);
			{r.ha, r.hb, r.hc} = i[31:29];
		end
		else if (op inside {op_fadd, op_fmul})
		begin
			r.a = fp_const(l, i[28:23]);
			r.b = fp_const(l, i[22:17]);
			r.c = fp_const(l, i[16:11]);
			{r.ha, r.hb, r.hc} = i[31:29];
		end
		else if (op == op_br)
		begin
			r.b  = i[30] ? ca : {{44{i[28]}}, i[28:11], 2'b00};
			r.hb = 1'b1;
		end
		else if (op inside {op_load, op_store})
		begin
			r.b  = i[30] ? ca : {{52{i[28]}}, i[28:17]};
			r.hb = 1'b1;
			if (op == op_store)
			begin
				r.c  = cb;
				r.hc = i[29];
			end
		end
		else if (op == op_fence)
		begin
			r.b  = {48'd0, i[22:7]};
			r.hb = 1'b1;
		end
		return r;
	endfunction

	// ========================================
	// Checks
	// ========================================

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_imm(string name, imm_t want, imm_t got);
		if (got !== want)
			abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, want, got));
	endtask

	task automatic check_flag(string name, logic want, logic got);
		if (got !== want)
			abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, want, got));
	endtask

	// Outputs settle after the rising edge, so they are read on the falling one
	initial
	begin
		result_t want;
		string   name;
		logic    vh1;
		logic    vh2;
		logic    seen;
		vh1  = 1'b0;
		vh2  = 1'b0;
		seen = 1'b0;
		forever
		begin
			@(negedge clk);
			check_flag("out_valid latency", vh2, out_valid);
			if (out_valid)
			begin
				if (exp_q.size() == 0)
					abort_run("out_valid went high with no instruction in flight");
				want = exp_q.pop_front();
				name = name_q.pop_front();
				check_imm({name, " imm_a"}, want.a, imm_a);
				check_imm({name, " imm_b"}, want.b, imm_b);
				check_imm({name, " imm_c"}, want.c, imm_c);
				check_flag({name, " has_imm_a"}, want.ha, has_imm_a);
				check_flag({name, " has_imm_b"}, want.hb, has_imm_b);
				check_flag({name, " has_imm_c"}, want.hc, has_imm_c);
				seen = 1'b1;
			end
			else
			begin
				check_flag("idle has_imm_a", 1'b0, has_imm_a);
				check_flag("idle has_imm_b", 1'b0, has_imm_b);
				check_flag("idle has_imm_c", 1'b0, has_imm_c);
				// Immediates stay at their reset value until the first result
				if (!seen)
				begin
					check_imm("reset imm_a", '0, imm_a);
					check_imm("reset imm_b", '0, imm_b);
					check_imm("reset imm_c", '0, imm_c);
				end
			end
			// in_valid seen here reaches out_valid two falling edges later
			vh2 = vh1;
			vh1 = in_valid;
		end
	end

	initial
	begin
		#((test_cycles + 40) * 8);
		abort_run("Timeout: the decode stage did not finish all tests in time");
	end

	// ========================================
	// Stimulus
	// ========================================

	function automatic line_t random_line();
		line_t l;
		for (int k = 0; k < slot_count; k++)
			l[k*slot_bits +: slot_bits] = $random(seed);
		return l;
	endfunction

	// Specials in slots 0 to 8 for the FP widening path
	function automatic line_t fp_line();
		line_t l;
		l = random_line();
		l[0*32 +: 32] = 32'h3fc00000;
		l[1*32 +: 32] = 32'h00000000;
		l[2*32 +: 32] = 32'h80000000;
		l[3*32 +: 32] = 32'h00000001;
		l[4*32 +: 32] = 32'h80400000;
		l[5*32 +: 32] = 32'h7f800000;
		l[6*32 +: 32] = 32'hff800000;
		l[7*32 +: 32] = 32'h7fc00001;
		l[8*32 +: 32] = 32'hc1200000;
		return l;
	endfunction

	// Index 0 to 5 are integer ops, then FP, branch, load, store and fence
	function automatic opcode_t op_by_index(int k);
		case (k)
			0:       return op_add;
			1:       return op_sub;
			2:       return op_and;
			3:       return op_or;
			4:       return op_xor;
			5:       return op_shl;
			6:       return op_fadd;
			7:       return op_fmul;
			8:       return op_br;
			9:       return op_load;
			10:      return op_store;
			default: return op_fence;
		endcase
	endfunction

	// Random flags, operand fields and rd under a given opcode
	function automatic instr_t make_ins(opcode_t op);
		return {3'($random(seed)), 22'($random(seed)), op};
	endfunction

	task automatic send(string name, instr_t i, line_t l);
		@(posedge clk);
		in_valid <= 1'b1;
		ins      <= i;
		line     <= l;
		exp_q.push_back(ref_decode(i, l));
		name_q.push_back(name);
	endtask

	// Idle cycles carry junk that must not reach the outputs
	task automatic idle();
		@(posedge clk);
		in_valid <= 1'b0;
		ins      <= $random(seed);
		line     <= random_line();
	endtask

	initial
	begin
		instr_t i;
		arst_n   <= 1'b0;
		in_valid <= 1'b0;
		ins      <= '0;
		line     <= '0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) idle();

		for (int k = 0; k < alu_tests; k++)
			send("alu", make_ins(op_by_index(k % 6)), random_line());
		// A 64-bit constant from the last slot has a zero high word
		i = make_ins(op_add);
		i[28:23] = 6'h3f;
		send("alu slot 15 size 64", i, random_line());

		for (int k = 0; k < fp_tests; k++)
		begin
			i = make_ins(op_by_index(6 + k % 2));
			i[28:23] = {2'b10, 4'(k)};
			i[22:17] = {2'b10, 4'(k + 5)};
			send("fp", i, fp_line());
		end

		for (int k = 0; k < br_tests; k++)
		begin
			i = make_ins(op_br);
			i[30] = k[0];
			if (k % 4 < 2)
				i[28] = 1'b1;
			send("branch", i, random_line());
		end

		for (int k = 0; k < mem_tests; k++)
			send("memory and fence", make_ins(op_by_index(9 + k % 3)), random_line());

		for (int k = 0; k < mix_tests; k++)
		begin
			send("mixed", make_ins(op_by_index(int'($unsigned($random(seed)) % 12))),
				random_line());
			repeat (int'($unsigned($random(seed)) % 3)) idle();
		end

		idle();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (3) @(posedge clk);
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: tb/decode_const_chk.sv
// ========================================
// Bound checks on the decode stage outputs
// Opcode of an output is the input register one cycle back
// ========================================

module decode_const_chk (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  in_valid,
	input logic                  out_valid,
	input const_isa_pkg::instr_t ins_q,
	input logic                  has_imm_a,
	input logic                  has_imm_b,
	input logic                  has_imm_c
);

	timeunit 1ns;
	timeprecision 1ps;

	import const_isa_pkg::*;

	// Fixed latency of two edges from in_valid to out_valid
	assert property (@(posedge clk) disable iff (!arst_n) out_valid == $past(in_valid, 2))
		else $error("out_valid did not follow in_valid by two cycles");

	// Flags carry meaning only next to out_valid
	assert property (@(posedge clk) disable iff (!arst_n)
		!out_valid |-> !(has_imm_a || has_imm_b || has_imm_c))
		else $error("an immediate flag is set while out_valid is low");

	// Branch, memory and fence use operand a only as a source for imm_b
	assert property (@(posedge clk) disable iff (!arst_n)
		has_imm_a |-> !($past(ins_q[6:0]) inside {op_br, op_load, op_store, op_fence}))
		else $error("has_imm_a set for a branch, memory or fence opcode");

endmodule

bind decode_const_stage decode_const_chk decode_const_chk_inst (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.ins_q     (ins_q),
	.has_imm_a (has_imm_a),
	.has_imm_b (has_imm_b),
	.has_imm_c (has_imm_c)
);

// File: design/decode_const_stage.sv
// ========================================
// Registered decode stage, two-cycle latency
// Flags are valid only while out_valid is high
// ========================================

module decode_const_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  const_isa_pkg::instr_t ins,
	input  const_line_pkg::line_t line,
	output logic                  out_valid,
	output const_line_pkg::imm_t  imm_a,
	output const_line_pkg::imm_t  imm_b,
	output const_line_pkg::imm_t  imm_c,
	output logic                  has_imm_a,
	output logic                  has_imm_b,
	output logic                  has_imm_c
);

	import const_line_pkg::*;
	import const_isa_pkg::*;

	// Input register
	logic   valid_q;
	instr_t ins_q;
	line_t  line_q;

	// Decoder results ahead of the output register
	imm_t dec_imm_a;
	imm_t dec_imm_b;
	imm_t dec_imm_c;
	logic dec_has_a;
	logic dec_has_b;
	logic dec_has_c;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= in_valid;
	end

	// Payload loads only with a valid instruction so idle cycles hold it
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			ins_q  <= ins;
			line_q <= line;
		end
	end

	decode_const decode_const_inst (
		.ins       (ins_q),
		.line      (line_q),
		.imm_a     (dec_imm_a),
		.imm_b     (dec_imm_b),
		.imm_c     (dec_imm_c),
		.has_imm_a (dec_has_a),
		.has_imm_b (dec_has_b),
		.has_imm_c (dec_has_c)
	);

	// Flags drop on idle cycles while the immediates hold their last value
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_valid <= 1'b0;
			imm_a     <= '0;
			imm_b     <= '0;
			imm_c     <= '0;
			has_imm_a <= 1'b0;
			has_imm_b <= 1'b0;
			has_imm_c <= 1'b0;
		end
		else
		begin
			out_valid <= valid_q;
			has_imm_a <= valid_q & dec_has_a;
			has_imm_b <= valid_q & dec_has_b;
			has_imm_c <= valid_q & dec_has_c;
			if (valid_q)
			begin
				imm_a <= dec_imm_a;
				imm_b <= dec_imm_b;
				imm_c <= dec_imm_c;
			end
		end
	end

endmodule

// File: design/decode_const.sv
// ========================================
// Combinational immediate decoder
// Unknown opcodes return zero with all flags low
// ========================================

module decode_const (
	input  const_isa_pkg::instr_t ins,
	input  const_line_pkg::line_t line,
	output const_line_pkg::imm_t  imm_a,
	output const_line_pkg::imm_t  imm_b,
	output const_line_pkg::imm_t  imm_c,
	output logic                  has_imm_a,
	output logic                  has_imm_b,
	output logic                  has_imm_c
);

	import const_line_pkg::*;
	import const_isa_pkg::*;

	// Per operand, index 0 is a, 1 is b and 2 is c
	slot_t      slot [3];
	size_code_t size [3];
	imm_t       cnst [3];
	imm_t       wide [3];
	imm_t       pick [3];
	logic       flag [3];

	// ========================================
	// Operand extraction
	// ========================================

	for (genvar i = 0; i < 3; i++)
	begin : g_opnd
		assign slot[i] = fn_opnd_slot(ins, opnd_t'(i));
		assign size[i] = fn_opnd_size(ins, opnd_t'(i));
		assign flag[i] = fn_opnd_is_const(ins, opnd_t'(i));

		const_slot_extract const_slot_extract_inst (
			.line  (line),
			.slot  (slot[i]),
			.size  (size[i]),
			.value (cnst[i])
		);

		// The slot word is the low half of the extracted value
		fp_widen_s2d fp_widen_s2d_inst (
			.single (cnst[i][31:0]),
			.double (wide[i])
		);

		// FP ops read a 32-bit constant as single precision
		assign pick[i] = (fn_is_fp(ins) && size[i] == sz32) ? wide[i] : cnst[i];
	end

	// ========================================
	// Selection by opcode class
	// ========================================

	always_comb
	begin
		imm_a     = '0;
		imm_b     = '0;
		imm_c     = '0;
		has_imm_a = 1'b0;
		has_imm_b = 1'b0;
		has_imm_c = 1'b0;
		if (fn_is_alu(ins) || fn_is_fp(ins))
		begin
			// Each immediate is passed even when its flag is clear
			imm_a     = pick[0];
			imm_b     = pick[1];
			imm_c     = pick[2];
			has_imm_a = flag[0];
			has_imm_b = flag[1];
			has_imm_c = flag[2];
		end
		else
		begin
			case (fn_opcode(ins))
				op_br:
				begin
					// Word displacement of 18 bits unless a line constant is flagged
					imm_b     = flag[1] ? cnst[0] : {{44{ins[28]}}, ins[28:11], 2'b00};
					has_imm_b = 1'b1;
				end
				op_load:
				begin
					imm_b     = flag[1] ? cnst[0] : {{52{ins[28]}}, ins[28:17]};
					has_imm_b = 1'b1;
				end
				op_store:
				begin
					imm_b     = flag[1] ? cnst[0] : {{52{ins[28]}}, ins[28:17]};
					has_imm_b = 1'b1;
					// Store data may itself be a line constant
					imm_c     = cnst[1];
					has_imm_c = flag[2];
				end
				op_fence:
				begin
					// The 16-bit fence mask is carried as an unsigned immediate
					imm_b     = {48'd0, ins[22:7]};
					has_imm_b = 1'b1;
				end
				default:
				begin
					imm_b = '0;
				end
			endcase
		end
	end

endmodule

// File: design/fp_widen_s2d.sv
// ========================================
// Single to double precision widening
// Denormals flush to a zero of the same sign
// ========================================

module fp_widen_s2d (
	input  logic [31:0]          single,
	output const_line_pkg::imm_t double
);

	import const_line_pkg::*;

	// Fields of the single-precision input
	logic                    sign;
	logic [7:0]              exp_s;
	logic [sp_frac_bits-1:0] frac_s;

	// Exponent moved from the single bias to the double bias
	logic [10:0]             exp_d;

	// Fraction placed at the top of the double fraction field
	logic [dp_frac_bits-1:0] frac_d;

	assign sign   = single[31];
	assign exp_s  = single[30:23];
	assign frac_s = single[sp_frac_bits-1:0];

	// A normal single exponent never overflows 11 bits after rebias
	assign exp_d  = 11'(exp_s) + 11'(dp_bias - sp_bias);

	// The low 29 fraction bits are always zero in a widened value
	assign frac_d = {frac_s, {(dp_frac_bits - sp_frac_bits){1'b0}}};

	always_comb
	begin
		if (exp_s == 8'h00)
		begin
			// Zero and denormal inputs keep only their sign
			double = {sign, {(imm_bits-1){1'b0}}};
		end
		else if (exp_s == 8'hff)
		begin
			// Infinity stays infinity and a NaN keeps its payload bits
			double = {sign, 11'h7ff, frac_d};
		end
		else
		begin
			double = {sign, exp_d, frac_d};
		end
	end

endmodule

// File: design/const_slot_extract.sv
// ========================================
// Pulls one sign-extended constant out of a line
// A 64-bit constant in slot 15 reads zero above bit 31
// ========================================

module const_slot_extract (
	input  const_line_pkg::line_t      line,
	input  const_line_pkg::slot_t      slot,
	input  const_line_pkg::size_code_t size,
	output const_line_pkg::imm_t       value
);

	import const_line_pkg::*;

	// Line moved down so the wanted slot starts at bit 0
	line_t shifted;

	// The logical shift brings in zeros from the top of the line, which
	// is what a 64-bit constant starting in the last slot needs
	always_comb
	begin
		shifted = line >> (slot * slot_bits);
	end

	// Keep the low bits named by the size code and copy the sign upward
	always_comb
	begin
		case (size)
			sz8:
			begin
				value = {{(imm_bits-8){shifted[7]}}, shifted[7:0]};
			end
			sz16:
			begin
				value = {{(imm_bits-16){shifted[15]}}, shifted[15:0]};
			end
			sz32:
			begin
				value = {{(imm_bits-32){shifted[31]}}, shifted[31:0]};
			end
			default:
			begin
				// Slot k is the low word, slot k+1 the high word
				value = shifted[imm_bits-1:0];
			end
		endcase
	end

endmodule

// File: design/const_isa_pkg.sv
// ========================================
// Instruction format and operand field access
// Opcodes outside the list decode with no immediates
// ========================================

package const_isa_pkg;

	import const_line_pkg::*;

	// Each operand field is a 4-bit slot under a 2-bit size code
	localparam int opnd_bits = 6;

	typedef logic [31:0] instr_t;

	typedef enum logic [6:0] {
		op_add   = 7'h01,
		op_sub   = 7'h02,
		op_and   = 7'h03,
		op_or    = 7'h04,
		op_xor   = 7'h05,
		op_shl   = 7'h06,
		op_fadd  = 7'h10,
		op_fmul  = 7'h11,
		op_br    = 7'h20,
		op_load  = 7'h30,
		op_store = 7'h31,
		op_fence = 7'h40
	} opcode_t;

	// Selects one of the three operand fields
	typedef enum logic [1:0] {opnd_a = 2'd0, opnd_b = 2'd1, opnd_c = 2'd2} opnd_t;

	function automatic opcode_t fn_opcode(instr_t ins);
		return opcode_t'(ins[6:0]);
	endfunction

	// Integer ops take all three operands straight from the line
	function automatic logic fn_is_alu(instr_t ins);
		opcode_t op;
		op = fn_opcode(ins);
		return op inside {op_add, op_sub, op_and, op_or, op_xor, op_shl};
	endfunction

	function automatic logic fn_is_fp(instr_t ins);
		opcode_t op;
		op = fn_opcode(ins);
		return op inside {op_fadd, op_fmul};
	endfunction

	// Operand a sits highest, c lowest, just under the flag bits
	function automatic logic [opnd_bits-1:0] fn_opnd_field(instr_t ins, opnd_t which);
		case (which)
			opnd_a:  return ins[28:23];
			opnd_b:  return ins[22:17];
			default: return ins[16:11];
		endcase
	endfunction

	function automatic slot_t fn_opnd_slot(instr_t ins, opnd_t which);
		logic [opnd_bits-1:0] field;
		field = fn_opnd_field(ins, which);
		return field[3:0];
	endfunction

	function automatic size_code_t fn_opnd_size(instr_t ins, opnd_t which);
		logic [opnd_bits-1:0] field;
		field = fn_opnd_field(ins, which);
		return size_code_t'(field[5:4]);
	endfunction

	// Flag bit 31 belongs to operand a, bit 30 to b and bit 29 to c
	function automatic logic fn_opnd_is_const(instr_t ins, opnd_t which);
		case (which)
			opnd_a:  return ins[31];
			opnd_b:  return ins[30];
			default: return ins[29];
		endcase
	endfunction

endpackage

// File: design/const_line_pkg.sv
// ========================================
// Cache-line geometry and immediate format
// A line holds 16 constant slots of 32 bits
// ========================================

package const_line_pkg;

	// Slot geometry of the instruction cache line
	localparam int slot_bits  = 32;
	localparam int slot_count = 16;
	localparam int line_bits  = slot_bits * slot_count;

	// Every immediate leaves the decoder at full register width
	localparam int imm_bits = 64;

	// IEEE single and double precision fields used by the widening path
	localparam int sp_bias      = 127;
	localparam int dp_bias      = 1023;
	localparam int sp_frac_bits = 23;
	localparam int dp_frac_bits = 52;

	typedef logic [line_bits-1:0]          line_t;
	typedef logic [imm_bits-1:0]           imm_t;
	typedef logic [$clog2(slot_count)-1:0] slot_t;

	// Size of a constant held in the line; 64 bits spans two slots
	typedef enum logic [1:0] {sz8 = 2'd0, sz16 = 2'd1, sz32 = 2'd2, sz64 = 2'd3} size_code_t;

endpackage
